/* rtl/cache_pkg.sv */
package cache_pkg;

	// byte address as seen by both cores
	typedef logic [31:0] addr_t;

	// one memory beat and one core word share this width
	typedef logic [63:0] data_t;
	typedef logic [7:0]  strb_t;

	// tag sits above the set number, the set number above the beat
	typedef logic [22:0] tag_t;
	typedef logic [3:0]  index_t;
	typedef logic [1:0]  beat_t;

	// one bit per way
	typedef logic [3:0]  way_t;

	localparam int LINE_BEATS = 4;
	localparam int NUM_WAYS   = 4;
	localparam int NUM_SETS   = 16;

	// held stable by the core while valid is high
	typedef struct packed {
		addr_t addr;
		logic  we;
		data_t wdata;
		strb_t wstrb;
	} cpu_req_t;

	// req is a level kept up until rlast or wdone
	typedef struct packed {
		logic  req;
		logic  we;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} mem_req_t;

	typedef struct packed {
		logic  rvalid;
		logic  rlast;
		data_t rdata;
		logic  wdone;
	} mem_rsp_t;

	// STORE is only reached by the data cache
	typedef enum logic [1:0] {
		LOOKUP,
		REFILL,
		STORE
	} cache_state_t;

endpackage

/* rtl/cache_tag_array.sv */
`timescale 1ns/1ns

module cache_tag_array (
	input  logic             clk,
	input  logic             rst,
	input  cache_pkg::addr_t addr,
	input  logic             fill,
	input  logic             advance,
	output cache_pkg::way_t  hit_way,
	output cache_pkg::way_t  victim_way
);
	import cache_pkg::*;

	tag_t                tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
	tag_t                tag;
	index_t              index;

	assign tag   = addr[31:9];
	assign index = addr[8:5];

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = valid_bits[w][index] && (tags[w][index] == tag);
		end
	end

	// new tag lands in whichever way the victim pointer marks
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill && victim_way[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
			victim_way <= 4'b0001;
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill && victim_way[w]) begin
					valid_bits[w][index] <= 1'b1;
				end
			end
			// one-hot rotate toward the higher ways
			if (advance) begin
				victim_way <= {victim_way[NUM_WAYS-2:0], victim_way[NUM_WAYS-1]};
			end
		end
	end

endmodule

/* rtl/cache_data_array.sv */
`timescale 1ns/1ns

module cache_data_array (
	input  logic              clk,
	input  logic              rd_en,
	input  cache_pkg::way_t   rd_way,
	input  cache_pkg::way_t   wr_way,
	input  cache_pkg::index_t index,
	input  cache_pkg::beat_t  beat,
	input  cache_pkg::data_t  wdata,
	input  cache_pkg::strb_t  wstrb,
	output cache_pkg::data_t  rdata
);
	import cache_pkg::*;

	localparam int ROWS = NUM_SETS * LINE_BEATS;

	data_t mem [NUM_WAYS][ROWS];
	logic [$bits(index_t)+$bits(beat_t)-1:0] row;

	// one row per beat, beats of a line are adjacent
	assign row = {index, beat};

	always_ff @(posedge clk) begin
		// byte-masked write, refill drives every strobe
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (wr_way[w]) begin
				for (int b = 0; b < $bits(strb_t); b++) begin
					if (wstrb[b]) begin
						mem[w][row][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end
		end
		// registered read, output holds between reads
		if (rd_en) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (rd_way[w]) begin
					rdata <= mem[w][row];
				end
			end
		end
	end

endmodule

/* rtl/dcache.sv */
`timescale 1ns/1ns

module dcache (
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  cache_pkg::cpu_req_t cpu_req,
	output logic                ready,
	output cache_pkg::data_t    rdata,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	cache_state_t state;
	way_t         hit_way;
	way_t         victim_way;
	way_t         wr_way;
	beat_t        refill_beat;
	beat_t        beat;
	data_t        wdata;
	strb_t        wstrb;
	logic         hit;
	logic         accept;
	logic         rd_en;
	logic         fill;
	logic         advance;

	assign hit = |hit_way;

	// a request is taken once, the ready cycle still shows the old one
	assign accept = valid && !ready && (state == LOOKUP);

	assign rd_en   = accept && !cpu_req.we && hit;
	assign fill    = (state == REFILL) && mem_rsp.rvalid && mem_rsp.rlast;
	assign advance = (state == LOOKUP) && !valid;

	// refill beats go to the victim, store hits update the hitting way
	always_comb begin
		wr_way = '0;
		if (state == REFILL && mem_rsp.rvalid) begin
			wr_way = victim_way;
		end else if (accept && cpu_req.we) begin
			wr_way = hit_way;
		end
	end

	assign beat  = (state == REFILL) ? refill_beat : cpu_req.addr[4:3];
	assign wdata = (state == REFILL) ? mem_rsp.rdata : cpu_req.wdata;
	assign wstrb = (state == REFILL) ? '1 : cpu_req.wstrb;

	// burst reads start at the line base, stores send the single beat
	always_comb begin
		mem_req       = '0;
		mem_req.wdata = cpu_req.wdata;
		mem_req.wstrb = cpu_req.wstrb;
		mem_req.we    = (state == STORE);
		mem_req.req   = (state == REFILL) || (state == STORE)
			|| (accept && !cpu_req.we && !hit);
		if (state == STORE) begin
			mem_req.addr = cpu_req.addr;
		end else begin
			mem_req.addr = {cpu_req.addr[31:5], 5'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= LOOKUP;
			ready       <= 1'b0;
			refill_beat <= '0;
		end else begin
			ready <= 1'b0;
			case (state)
				LOOKUP: begin
					if (accept && cpu_req.we) begin
						state <= STORE;
					end else if (accept && !hit) begin
						state       <= REFILL;
						refill_beat <= '0;
					end else if (accept) begin
						// load hit, data leaves the array next cycle
						ready <= 1'b1;
					end
				end
				REFILL: begin
					if (mem_rsp.rvalid) begin
						refill_beat <= refill_beat + 1'b1;
					end
					// look up again once the line is in
					if (fill) begin
						state <= LOOKUP;
					end
				end
				STORE: begin
					if (mem_rsp.wdone) begin
						state <= LOOKUP;
						ready <= 1'b1;
					end
				end
				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	cache_tag_array tags_i (
		.clk        (clk),
		.rst        (rst),
		.addr       (cpu_req.addr),
		.fill       (fill),
		.advance    (advance),
		.hit_way    (hit_way),
		.victim_way (victim_way)
	);

	cache_data_array data_i (
		.clk    (clk),
		.rd_en  (rd_en),
		.rd_way (hit_way),
		.wr_way (wr_way),
		.index  (cpu_req.addr[8:5]),
		.beat   (beat),
		.wdata  (wdata),
		.wstrb  (wstrb),
		.rdata  (rdata)
	);

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ns

module icache (
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  cache_pkg::addr_t    fetch_addr,
	output logic                ready,
	output cache_pkg::data_t    rdata,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	cache_state_t state;
	way_t         hit_way;
	way_t         victim_way;
	way_t         wr_way;
	beat_t        refill_beat;
	logic         hit;
	logic         accept;
	logic         fill;

	assign hit    = |hit_way;
	assign accept = valid && !ready && (state == LOOKUP);
	assign fill   = (state == REFILL) && mem_rsp.rvalid && mem_rsp.rlast;

	// only refill writes the arrays
	assign wr_way = (state == REFILL && mem_rsp.rvalid) ? victim_way : '0;

	// read-only port, we and the write fields stay low
	always_comb begin
		mem_req      = '0;
		mem_req.req  = (state == REFILL) || (accept && !hit);
		mem_req.addr = {fetch_addr[31:5], 5'b0};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= LOOKUP;
			ready       <= 1'b0;
			refill_beat <= '0;
		end else begin
			ready <= 1'b0;
			case (state)
				LOOKUP: begin
					if (accept && !hit) begin
						state       <= REFILL;
						refill_beat <= '0;
					end else if (accept) begin
						ready <= 1'b1;
					end
				end
				REFILL: begin
					if (mem_rsp.rvalid) begin
						refill_beat <= refill_beat + 1'b1;
					end
					if (fill) begin
						state <= LOOKUP;
					end
				end
				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	cache_tag_array tags_i (
		.clk        (clk),
		.rst        (rst),
		.addr       (fetch_addr),
		.fill       (fill),
		.advance    ((state == LOOKUP) && !valid),
		.hit_way    (hit_way),
		.victim_way (victim_way)
	);

	cache_data_array data_i (
		.clk    (clk),
		.rd_en  (accept && hit),
		.rd_way (hit_way),
		.wr_way (wr_way),
		.index  (fetch_addr[8:5]),
		.beat   ((state == REFILL) ? refill_beat : fetch_addr[4:3]),
		.wdata  (mem_rsp.rdata),
		.wstrb  ('1),
		.rdata  (rdata)
	);

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::mem_req_t d_req,
	output cache_pkg::mem_rsp_t d_rsp,
	input  cache_pkg::mem_req_t i_req,
	output cache_pkg::mem_rsp_t i_rsp,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	// owner and last_served use 0 for dcache and 1 for icache
	logic busy;
	logic owner;
	logic last_served;
	logic pick;
	logic sel;

	// on a tie serve the master that waited last time
	always_comb begin
		if (d_req.req && i_req.req) begin
			pick = !last_served;
		end else begin
			pick = i_req.req;
		end
	end

	// free bus grants in the same cycle
	assign sel     = busy ? owner : pick;
	assign mem_req = sel ? i_req : d_req;

	// the master without the bus sees every strobe low
	assign d_rsp = (busy && !owner) ? mem_rsp : '0;
	assign i_rsp = (busy && owner) ? mem_rsp : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy        <= 1'b0;
			owner       <= 1'b0;
			// dcache wins the first tie
			last_served <= 1'b1;
		end else if (busy) begin
			if (mem_rsp.rlast || mem_rsp.wdone) begin
				busy <= 1'b0;
			end
		end else if (d_req.req || i_req.req) begin
			busy        <= 1'b1;
			owner       <= pick;
			last_served <= pick;
		end
	end

endmodule

/* rtl/main_memory.sv */
`timescale 1ns/1ns

module main_memory #(
	parameter int MEM_WORDS = 512
) (
	input  logic                clk,
	input  logic                rst,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::mem_rsp_t mem_rsp
);
	import cache_pkg::*;

	data_t       mem [MEM_WORDS];
	logic [31:0] req_word;
	logic [31:0] burst_word;
	beat_t       beat_cnt;
	logic        accept;

	// word address wraps at the memory depth
	assign req_word = (mem_req.addr >> 3) % MEM_WORDS;

	// idle whenever no read beat or write ack is on the bus
	assign accept = mem_req.req && !mem_rsp.rvalid && !mem_rsp.wdone;

	always_ff @(posedge clk) begin
		if (rst) begin
			// byte address on top, its inverse below
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= {32'(i * 8), ~32'(i * 8)};
			end
			mem_rsp.rvalid <= 1'b0;
			mem_rsp.rlast  <= 1'b0;
			mem_rsp.wdone  <= 1'b0;
			beat_cnt       <= '0;
		end else begin
			mem_rsp.wdone <= 1'b0;
			if (accept && mem_req.we) begin
				for (int b = 0; b < $bits(strb_t); b++) begin
					if (mem_req.wstrb[b]) begin
						mem[req_word][8*b +: 8] <= mem_req.wdata[8*b +: 8];
					end
				end
				mem_rsp.wdone <= 1'b1;
			end else if (accept) begin
				// first beat goes out the cycle after acceptance
				mem_rsp.rvalid <= 1'b1;
				mem_rsp.rlast  <= 1'b0;
				mem_rsp.rdata  <= mem[req_word];
				burst_word     <= req_word;
				beat_cnt       <= 2'd1;
			end else if (mem_rsp.rlast) begin
				mem_rsp.rvalid <= 1'b0;
				mem_rsp.rlast  <= 1'b0;
			end else if (mem_rsp.rvalid) begin
				mem_rsp.rdata <= mem[(burst_word + 32'(beat_cnt)) % MEM_WORDS];
				mem_rsp.rlast <= (beat_cnt == beat_t'(LINE_BEATS - 1));
				beat_cnt      <= beat_cnt + 1'b1;
			end
		end
	end

endmodule

/* rtl/cache_subsystem_top.sv */
`timescale 1ns/1ns

module cache_subsystem_top #(
	parameter int MEM_WORDS = 512
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                d_valid,
	input  cache_pkg::cpu_req_t d_req,
	output logic                d_ready,
	output cache_pkg::data_t    d_rdata,
	input  logic                i_valid,
	input  cache_pkg::addr_t    i_addr,
	output logic                i_ready,
	output cache_pkg::data_t    i_rdata
);
	import cache_pkg::*;

	// per-cache bus and the shared bus behind the arbiter
	mem_req_t d_mem_req;
	mem_rsp_t d_mem_rsp;
	mem_req_t i_mem_req;
	mem_rsp_t i_mem_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	dcache dcache_i (
		.clk     (clk),
		.rst     (rst),
		.valid   (d_valid),
		.cpu_req (d_req),
		.ready   (d_ready),
		.rdata   (d_rdata),
		.mem_req (d_mem_req),
		.mem_rsp (d_mem_rsp)
	);

	icache icache_i (
		.clk        (clk),
		.rst        (rst),
		.valid      (i_valid),
		.fetch_addr (i_addr),
		.ready      (i_ready),
		.rdata      (i_rdata),
		.mem_req    (i_mem_req),
		.mem_rsp    (i_mem_rsp)
	);

	mem_arbiter arbiter_i (
		.clk     (clk),
		.rst     (rst),
		.d_req   (d_mem_req),
		.d_rsp   (d_mem_rsp),
		.i_req   (i_mem_req),
		.i_rsp   (i_mem_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	main_memory #(
		.MEM_WORDS (MEM_WORDS)
	) memory_i (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

/* sim/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb;
	import cache_pkg::*;

	localparam int MEM_WORDS = 1024;
	localparam int TIMEOUT   = 200;
	// data lives in the upper half of memory, fetches in the lower half
	localparam addr_t DATA_BASE = 32'(MEM_WORDS * 4);

	logic     clk;
	logic     rst;
	logic     d_valid;
	cpu_req_t d_req;
	logic     d_ready;
	data_t    d_rdata;
	logic     i_valid;
	addr_t    i_addr;
	logic     i_ready;
	data_t    i_rdata;

	// reference copy of the backing memory
	data_t       model [MEM_WORDS];
	logic [31:0] seed;

	cache_subsystem_top #(
		.MEM_WORDS (MEM_WORDS)
	) dut_i (
		.clk     (clk),
		.rst     (rst),
		.d_valid (d_valid),
		.d_req   (d_req),
		.d_ready (d_ready),
		.d_rdata (d_rdata),
		.i_valid (i_valid),
		.i_addr  (i_addr),
		.i_ready (i_ready),
		.i_rdata (i_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// lcg, upper bits are the useful ones
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// byte address of the word on top, its inverse below
	function automatic data_t reset_pattern(input int i);
		logic [31:0] byte_addr;
		byte_addr = 32'(i) << 3;
		return {byte_addr, ~byte_addr};
	endfunction

	function automatic int word_of(input addr_t addr);
		return int'((addr >> 3) % MEM_WORDS);
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
		data_t res;
		res = old;
		for (int b = 0; b < 8; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
		$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		$display("sim failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_problem(input string what);
		$display("%0t ns %s", $time, what);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	// one core request on the data port, called 1 ns after an edge
	task automatic data_access(input addr_t addr, input logic we, input data_t wdata,
			input strb_t wstrb, output int cycles);
		data_t expected;
		int    w;
		w             = word_of(addr);
		d_req.addr    = addr;
		d_req.we      = we;
		d_req.wdata   = wdata;
		d_req.wstrb   = wstrb;
		d_valid       = 1'b1;
		cycles        = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			assert (cycles <= TIMEOUT) else report_problem("timeout waiting for d_ready");
		end while (!d_ready);
		if (we) begin
			model[w] = merge_bytes(model[w], wdata, wstrb);
		end else begin
			expected = model[w];
			assert (d_rdata == expected) else report_mismatch("d_rdata", expected, d_rdata);
		end
		d_valid = 1'b0;
		// ready is a single-cycle pulse
		@(posedge clk);
		#1;
		assert (!d_ready) else report_mismatch("d_ready", 64'(0), 64'(d_ready));
	endtask

	task automatic fetch(input addr_t addr);
		data_t expected;
		int    cycles;
		expected = reset_pattern(word_of(addr));
		i_addr   = addr;
		i_valid  = 1'b1;
		cycles   = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			assert (cycles <= TIMEOUT) else report_problem("timeout waiting for i_ready");
		end while (!i_ready);
		assert (i_rdata == expected) else report_mismatch("i_rdata", expected, i_rdata);
		i_valid = 1'b0;
		@(posedge clk);
		#1;
		assert (!i_ready) else report_mismatch("i_ready", 64'(0), 64'(i_ready));
	endtask

	// roughly half stores, random strobes, 128 words of data space
	task automatic random_data_access();
		logic [31:0] rnd;
		logic [31:0] rnd_strb;
		data_t       wdata;
		int          lat;
		rnd      = next_random();
		rnd_strb = next_random();
		wdata    = {next_random(), next_random()};
		data_access(DATA_BASE | {22'b0, rnd[22:16], 3'b000}, rnd[28], wdata,
			rnd_strb[23:16], lat);
	endtask

	initial begin
		int          lat;
		logic [31:0] rnd;
		addr_t       addrs [8];
		addr_t       fetch_addr;
		logic [3:0]  set;
		seed    = 32'h17b249bb;
		rst     = 1'b1;
		d_valid = 1'b0;
		d_req   = '0;
		i_valid = 1'b0;
		i_addr  = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			model[i] = reset_pattern(i);
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		assert (!d_ready) else report_mismatch("d_ready", 64'(0), 64'(d_ready));
		assert (!i_ready) else report_mismatch("i_ready", 64'(0), 64'(i_ready));

		// cold loads then an immediate reload that has to hit
		for (int k = 0; k < 8; k++) begin
			rnd      = next_random();
			addrs[k] = DATA_BASE | {22'b0, rnd[22:16], 3'b000};
			data_access(addrs[k], 1'b0, '0, '0, lat);
			data_access(addrs[k], 1'b0, '0, '0, lat);
			assert (lat == 1) else report_mismatch("d_ready latency", 64'(1), 64'(lat));
		end
		for (int k = 0; k < 8; k++) begin
			data_access(addrs[k], 1'b0, '0, '0, lat);
		end

		// mixed stores and loads, cached and uncached lines
		repeat (200) begin
			random_data_access();
		end

		// six lines in one set push out older ways
		rnd = next_random();
		set = rnd[19:16];
		for (int k = 0; k < 6; k++) begin
			rnd = next_random();
			data_access(DATA_BASE | {20'b0, 3'(k), set, rnd[17:16], 3'b000}, 1'b0, '0, '0, lat);
		end
		for (int k = 0; k < 3; k++) begin
			rnd = next_random();
			data_access(DATA_BASE | {20'b0, 3'(k), set, rnd[17:16], 3'b000}, 1'b0, '0, '0, lat);
		end

		// both ports compete for the memory bus
		repeat (40) begin
			rnd        = next_random();
			fetch_addr = {20'b0, rnd[24:16], 3'b000};
			fork
				random_data_access();
				fetch(fetch_addr);
			join
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* verilog.f */
rtl/cache_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/dcache.sv
rtl/icache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/cache_subsystem_top.sv
sim/cache_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = cache_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
